//--- hw/vrf_pkg.sv
// Lane geometry, element width encoding and VRF word address layout, referenced by scoped name
package vrf_pkg;

  //////////////////////////////////////////////////////////////////////////////
  // Lane geometry
  //////////////////////////////////////////////////////////////////////////////

  // Banks in the lane VRF
  localparam int unsigned NR_BANKS = 8;
  // One requester per operand queue
  localparam int unsigned NR_QUEUES = 4;
  localparam int unsigned NR_VREGS = 32;
  // 64-bit words a vector register occupies in one lane
  localparam int unsigned VREG_WORDS = 16;
  localparam int unsigned WORD_BYTES = 8;

  // Address field widths
  localparam int unsigned BANK_W = 3;
  localparam int unsigned ROW_W = 6;
  localparam int unsigned ADDR_W = 9;

  // Vector length in elements, up to 128 at 8-bit width
  localparam int unsigned VL_W = 8;
  localparam int unsigned WCNT_W = 8;

  // Index of an operand queue, also the tag on a VRF access
  localparam int unsigned QUEUE_W = $clog2(NR_QUEUES);

  //////////////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////////////

  // Log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  // Word address, counted flat by the requesters and split into row and bank
  // by the arbiter. Consecutive words sit on consecutive banks
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    struct packed {
      logic [ROW_W-1:0]  row;
      logic [BANK_W-1:0] bank;
    } split;
  } vrf_addr_u;

endpackage

//--- hw/operand_cmd_decoder.sv
// Combinational decode of each operand queue command into a start word address and a word count
`timescale 1ns/1ps

module operand_cmd_decoder (
  input  logic [vrf_pkg::NR_QUEUES-1:0][$clog2(vrf_pkg::NR_VREGS)-1:0] cmd_vs_i,
  input  logic [vrf_pkg::NR_QUEUES-1:0][vrf_pkg::VL_W-1:0]            cmd_vl_i,
  input  vrf_pkg::eew_e [vrf_pkg::NR_QUEUES-1:0]                      cmd_eew_i,
  output vrf_pkg::vrf_addr_u [vrf_pkg::NR_QUEUES-1:0]                 start_addr_o,
  output logic [vrf_pkg::NR_QUEUES-1:0][vrf_pkg::WCNT_W-1:0]          word_count_o
);

  //////////////////////////////////////////////////////////////////////////////
  // Base address
  //////////////////////////////////////////////////////////////////////////////

  // Each register owns a contiguous block of words in the lane
  always_comb begin : p_start_addr
    for (int q = 0; q < vrf_pkg::NR_QUEUES; q++) begin
      start_addr_o[q].flat = vrf_pkg::ADDR_W'(cmd_vs_i[q] * vrf_pkg::VREG_WORDS);
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Word count
  //////////////////////////////////////////////////////////////////////////////

  // Operand length in bytes, then rounded up to whole 64-bit words.
  // The widest element equals one word, so the shift never needs more
  // than log2(WORD_BYTES) extra bits
  always_comb begin : p_word_count
    logic [vrf_pkg::VL_W+$clog2(vrf_pkg::WORD_BYTES)-1:0] byte_len;

    byte_len = '0;
    for (int q = 0; q < vrf_pkg::NR_QUEUES; q++) begin
      byte_len                     = '0;
      byte_len[vrf_pkg::VL_W-1:0]  = cmd_vl_i[q];
      byte_len                     = byte_len << cmd_eew_i[q];

      // A zero length rounds to a zero count on its own
      word_count_o[q] = vrf_pkg::WCNT_W'(
        (byte_len + (vrf_pkg::WORD_BYTES - 1)) >> $clog2(vrf_pkg::WORD_BYTES)
      );
    end
  end

endmodule

//--- hw/operand_requester.sv
// Per-queue requester that walks an operand's VRF words one grant at a time
`timescale 1ns/1ps

module operand_requester (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Command from the lane sequencer, already decoded
  input  logic                        cmd_valid_i,
  output logic                        cmd_ready_o,
  input  vrf_pkg::vrf_addr_u          start_addr_i,
  input  logic [vrf_pkg::WCNT_W-1:0]  word_count_i,
  // Operand queue flow control
  input  logic                        operand_queue_ready_i,
  // Request towards the bank arbiter
  output logic                        rd_req_o,
  output vrf_pkg::vrf_addr_u          rd_addr_o,
  input  logic                        rd_gnt_i
);

  // High in REQUESTING, low in IDLE
  logic busy_q, busy_d;

  // Next word to read and words still to go
  vrf_pkg::vrf_addr_u          addr_q, addr_d;
  logic [vrf_pkg::WCNT_W-1:0]  count_q, count_d;

  logic last_gnt;
  logic cmd_xfer;

  //////////////////////////////////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////////////////////////////////

  // Grant of the final word frees the requester in the same cycle
  assign last_gnt = busy_q && rd_gnt_i && (count_q == vrf_pkg::WCNT_W'(1));

  assign cmd_ready_o = !busy_q || last_gnt;
  assign cmd_xfer    = cmd_valid_i && cmd_ready_o;

  // Hold off while the operand queue has no room
  assign rd_req_o  = busy_q && operand_queue_ready_i;
  assign rd_addr_o = addr_q;

  //////////////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_next
    busy_d  = busy_q;
    addr_d  = addr_q;
    count_d = count_q;

    if (cmd_xfer) begin
      // Zero words means nothing to fetch, stay IDLE
      busy_d  = (word_count_i != '0);
      addr_d  = start_addr_i;
      count_d = word_count_i;
    end else if (busy_q && rd_gnt_i) begin
      // Move on to the next bank
      addr_d.flat = addr_q.flat + 1'b1;
      count_d     = count_q - 1'b1;
      busy_d      = !last_gnt;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_regs
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      count_q <= '0;
    end else begin
      busy_q  <= busy_d;
      count_q <= count_d;
    end
  end

  always_ff @(posedge clk_i) begin : p_addr_reg
    addr_q <= addr_d;
  end

endmodule

//--- hw/vrf_bank_arbiter.sv
// Per-bank VRF arbitration: write-back first, then round-robin among the operand requesters
`timescale 1ns/1ps

module vrf_bank_arbiter (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  // Read requesters
  input  logic [vrf_pkg::NR_QUEUES-1:0]                         rd_req_i,
  input  vrf_pkg::vrf_addr_u [vrf_pkg::NR_QUEUES-1:0]           rd_addr_i,
  output logic [vrf_pkg::NR_QUEUES-1:0]                         rd_gnt_o,
  // Result write-back
  input  logic                                                  wb_req_i,
  input  vrf_pkg::vrf_addr_u                                    wb_addr_i,
  input  logic [vrf_pkg::WORD_BYTES*8-1:0]                      wb_wdata_i,
  input  logic [vrf_pkg::WORD_BYTES-1:0]                        wb_be_i,
  output logic                                                  wb_gnt_o,
  // VRF bank ports
  output logic [vrf_pkg::NR_BANKS-1:0]                          vrf_req_o,
  output logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::ROW_W-1:0]      vrf_addr_o,
  output logic [vrf_pkg::NR_BANKS-1:0]                          vrf_wen_o,
  output logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::WORD_BYTES*8-1:0] vrf_wdata_o,
  output logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::WORD_BYTES-1:0] vrf_be_o,
  output logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::QUEUE_W-1:0]    vrf_tgt_opqueue_o
);

  // Write-back targets this bank
  logic [vrf_pkg::NR_BANKS-1:0] wb_hit;
  // A read wins this bank
  logic [vrf_pkg::NR_BANKS-1:0] rd_sel;
  logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::QUEUE_W-1:0] winner;
  logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::NR_QUEUES-1:0] rd_gnt_bank;

  // Queue with the highest read priority on each bank
  logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::QUEUE_W-1:0] ptr_q;

  //////////////////////////////////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_arbitrate
    logic                        found;
    logic [vrf_pkg::QUEUE_W-1:0] idx;

    found       = 1'b0;
    idx         = '0;
    wb_hit      = '0;
    rd_sel      = '0;
    winner      = '0;
    rd_gnt_bank = '0;

    for (int b = 0; b < vrf_pkg::NR_BANKS; b++) begin
      wb_hit[b] = wb_req_i && (wb_addr_i.split.bank == vrf_pkg::BANK_W'(b));

      // First requester at or after the pointer
      found = 1'b0;
      for (int i = 0; i < vrf_pkg::NR_QUEUES; i++) begin
        idx = vrf_pkg::QUEUE_W'((ptr_q[b] + i) % vrf_pkg::NR_QUEUES);
        if (!found && rd_req_i[idx] &&
            (rd_addr_i[idx].split.bank == vrf_pkg::BANK_W'(b))) begin
          found     = 1'b1;
          winner[b] = idx;
        end
      end

      // The write-back always takes its bank
      rd_sel[b] = found && !wb_hit[b];
      if (rd_sel[b]) begin
        rd_gnt_bank[b][winner[b]] = 1'b1;
      end
    end
  end

  // Each requester targets one bank, so OR the bank grants together
  always_comb begin : p_grants
    rd_gnt_o = '0;
    wb_gnt_o = 1'b0;
    for (int b = 0; b < vrf_pkg::NR_BANKS; b++) begin
      rd_gnt_o = rd_gnt_o | rd_gnt_bank[b];
      wb_gnt_o = wb_gnt_o | wb_hit[b];
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Bank ports
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_ports
    for (int b = 0; b < vrf_pkg::NR_BANKS; b++) begin
      vrf_req_o[b]         = wb_hit[b] || rd_sel[b];
      vrf_wen_o[b]         = wb_hit[b];
      vrf_addr_o[b]        = '0;
      vrf_wdata_o[b]       = '0;
      vrf_be_o[b]          = '0;
      vrf_tgt_opqueue_o[b] = '0;
      if (wb_hit[b]) begin
        vrf_addr_o[b]  = wb_addr_i.split.row;
        vrf_wdata_o[b] = wb_wdata_i;
        vrf_be_o[b]    = wb_be_i;
      end else if (rd_sel[b]) begin
        vrf_addr_o[b]        = rd_addr_i[winner[b]].split.row;
        vrf_tgt_opqueue_o[b] = winner[b];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Round-robin pointers
  //////////////////////////////////////////////////////////////////////////////

  // Move past the last read winner, writes leave the pointer alone
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptr
    if (!rst_ni) begin
      ptr_q <= '0;
    end else begin
      for (int b = 0; b < vrf_pkg::NR_BANKS; b++) begin
        if (rd_sel[b]) begin
          ptr_q[b] <= vrf_pkg::QUEUE_W'((winner[b] + 1) % vrf_pkg::NR_QUEUES);
        end
      end
    end
  end

endmodule

//--- hw/lane_operand_requester.sv
// Lane operand requester top: decodes queue commands, walks operands and arbitrates VRF banks
`timescale 1ns/1ps

module lane_operand_requester (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  // Operand queue commands
  input  logic [vrf_pkg::NR_QUEUES-1:0]                           cmd_valid_i,
  output logic [vrf_pkg::NR_QUEUES-1:0]                           cmd_ready_o,
  input  logic [vrf_pkg::NR_QUEUES-1:0][$clog2(vrf_pkg::NR_VREGS)-1:0] cmd_vs_i,
  input  logic [vrf_pkg::NR_QUEUES-1:0][vrf_pkg::VL_W-1:0]        cmd_vl_i,
  input  vrf_pkg::eew_e [vrf_pkg::NR_QUEUES-1:0]                  cmd_eew_i,
  // Operand queues
  input  logic [vrf_pkg::NR_QUEUES-1:0]                           operand_queue_ready_i,
  output logic [vrf_pkg::NR_QUEUES-1:0]                           operand_issued_o,
  // Result write-back, flat word address
  input  logic                                                    wb_req_i,
  input  logic [vrf_pkg::ADDR_W-1:0]                              wb_addr_i,
  input  logic [vrf_pkg::WORD_BYTES*8-1:0]                        wb_wdata_i,
  input  logic [vrf_pkg::WORD_BYTES-1:0]                          wb_be_i,
  output logic                                                    wb_gnt_o,
  // VRF bank ports
  output logic [vrf_pkg::NR_BANKS-1:0]                            vrf_req_o,
  output logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::ROW_W-1:0]        vrf_addr_o,
  output logic [vrf_pkg::NR_BANKS-1:0]                            vrf_wen_o,
  output logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::WORD_BYTES*8-1:0] vrf_wdata_o,
  output logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::WORD_BYTES-1:0]   vrf_be_o,
  output logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::QUEUE_W-1:0]      vrf_tgt_opqueue_o
);

  vrf_pkg::vrf_addr_u [vrf_pkg::NR_QUEUES-1:0]        start_addr;
  logic [vrf_pkg::NR_QUEUES-1:0][vrf_pkg::WCNT_W-1:0] word_count;

  logic [vrf_pkg::NR_QUEUES-1:0]                      rd_req;
  vrf_pkg::vrf_addr_u [vrf_pkg::NR_QUEUES-1:0]        rd_addr;
  logic [vrf_pkg::NR_QUEUES-1:0]                      rd_gnt;

  // A read grant is an issued word, the VRF never stalls
  assign operand_issued_o = rd_gnt;

  operand_cmd_decoder u_decoder (
    .cmd_vs_i    (cmd_vs_i),
    .cmd_vl_i    (cmd_vl_i),
    .cmd_eew_i   (cmd_eew_i),
    .start_addr_o(start_addr),
    .word_count_o(word_count)
  );

  for (genvar q = 0; q < vrf_pkg::NR_QUEUES; q++) begin : gen_requester
    operand_requester u_requester (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .cmd_valid_i          (cmd_valid_i[q]),
      .cmd_ready_o          (cmd_ready_o[q]),
      .start_addr_i         (start_addr[q]),
      .word_count_i         (word_count[q]),
      .operand_queue_ready_i(operand_queue_ready_i[q]),
      .rd_req_o             (rd_req[q]),
      .rd_addr_o            (rd_addr[q]),
      .rd_gnt_i             (rd_gnt[q])
    );
  end

  vrf_bank_arbiter u_arbiter (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .rd_req_i         (rd_req),
    .rd_addr_i        (rd_addr),
    .rd_gnt_o         (rd_gnt),
    .wb_req_i         (wb_req_i),
    .wb_addr_i        (wb_addr_i),
    .wb_wdata_i       (wb_wdata_i),
    .wb_be_i          (wb_be_i),
    .wb_gnt_o         (wb_gnt_o),
    .vrf_req_o        (vrf_req_o),
    .vrf_addr_o       (vrf_addr_o),
    .vrf_wen_o        (vrf_wen_o),
    .vrf_wdata_o      (vrf_wdata_o),
    .vrf_be_o         (vrf_be_o),
    .vrf_tgt_opqueue_o(vrf_tgt_opqueue_o)
  );

endmodule

//--- tests/tb_clock_gen.sv
// Clock and power-on reset source for the operand requester testbench, instantiated by its top
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int unsigned HALF_PERIOD  = 5;
  localparam int unsigned RESET_CYCLES = 4;

  initial begin : p_clock
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin : p_reset
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- tests/tb_lane_operand_requester.sv
// Simulation top that replays the command vectors file against the operand requester and checks accesses
`timescale 1ns/1ps

module tb_lane_operand_requester;

  localparam int unsigned MAX_CMDS = 64;
  localparam int unsigned FIELDS   = 4;

  logic clk, rst_n;
  logic [vrf_pkg::NR_QUEUES-1:0]                           cmd_valid, cmd_ready;
  logic [vrf_pkg::NR_QUEUES-1:0][4:0]                      cmd_vs;
  logic [vrf_pkg::NR_QUEUES-1:0][vrf_pkg::VL_W-1:0]        cmd_vl;
  vrf_pkg::eew_e [vrf_pkg::NR_QUEUES-1:0]                  cmd_eew;
  logic [vrf_pkg::NR_QUEUES-1:0]                           oq_ready, issued;
  logic                                                    wb_req, wb_gnt;
  logic [vrf_pkg::ADDR_W-1:0]                              wb_addr;
  logic [63:0]                                             wb_wdata;
  logic [7:0]                                              wb_be;
  logic [vrf_pkg::NR_BANKS-1:0]                            vrf_req, vrf_wen;
  logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::ROW_W-1:0]        vrf_addr;
  logic [vrf_pkg::NR_BANKS-1:0][63:0]                      vrf_wdata;
  logic [vrf_pkg::NR_BANKS-1:0][7:0]                       vrf_be;
  logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::QUEUE_W-1:0]      vrf_tgt;

  // Each command line holds queue, vs, vl and eew
  logic [7:0] vectors [0:MAX_CMDS*FIELDS-1];
  int unsigned n_cmds, total_words, limit, cycles;

  // Reference model state per queue
  int unsigned                cmd_idx    [vrf_pkg::NR_QUEUES][$];
  logic [vrf_pkg::ADDR_W-1:0] exp_addr   [vrf_pkg::NR_QUEUES][$];
  int unsigned                next_cmd   [vrf_pkg::NR_QUEUES];
  int unsigned                issued_cnt [vrf_pkg::NR_QUEUES];
  int unsigned                cur_words  [vrf_pkg::NR_QUEUES];
  bit                         started    [vrf_pkg::NR_QUEUES];

  tb_clock_gen u_clock_gen (.clk_o(clk), .rst_no(rst_n));

  lane_operand_requester u_dut (
    .clk_i(clk), .rst_ni(rst_n),
    .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready), .cmd_vs_i(cmd_vs),
    .cmd_vl_i(cmd_vl), .cmd_eew_i(cmd_eew),
    .operand_queue_ready_i(oq_ready), .operand_issued_o(issued),
    .wb_req_i(wb_req), .wb_addr_i(wb_addr), .wb_wdata_i(wb_wdata), .wb_be_i(wb_be),
    .wb_gnt_o(wb_gnt),
    .vrf_req_o(vrf_req), .vrf_addr_o(vrf_addr), .vrf_wen_o(vrf_wen),
    .vrf_wdata_o(vrf_wdata), .vrf_be_o(vrf_be), .vrf_tgt_opqueue_o(vrf_tgt)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Operand bytes rounded up to whole VRF words
  function automatic int unsigned words_for(logic [7:0] vl, logic [1:0] eew);
    int unsigned nbytes;
    nbytes = int'(vl) * (1 << eew);
    return (nbytes + vrf_pkg::WORD_BYTES - 1) / vrf_pkg::WORD_BYTES;
  endfunction

  task automatic fail_stop(string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
    assert (act === exp) else begin
      fail_stop($sformatf("CHECK FAILED t=%0t %s exp=%0h got=%0h", $time, name, exp, act));
    end
  endtask

  task automatic check_idle_outputs();
    check_value("vrf_req_o", '0, vrf_req);
    check_value("operand_issued_o", '0, issued);
    check_value("cmd_ready_o", {vrf_pkg::NR_QUEUES{1'b1}}, cmd_ready);
  endtask

  task automatic load_vectors();
    int unsigned q, base;
    // Unloaded entries carry the top bit that no queue number has
    for (int i = 0; i < MAX_CMDS * FIELDS; i++) vectors[i] = {1'b1, 7'(i)};
    $readmemh("tests/operand_tests.mem", vectors);
    n_cmds = 0;
    while (n_cmds < MAX_CMDS && !vectors[n_cmds*FIELDS][7]) n_cmds++;
    assert (n_cmds > 0) else fail_stop("No commands could be read from the vectors file");
    total_words = 0;
    for (int i = 0; i < n_cmds; i++) begin
      base = i * FIELDS;
      q    = vectors[base];
      assert (q < vrf_pkg::NR_QUEUES) else begin
        fail_stop("A command names a queue that does not exist");
      end
      cmd_idx[q].push_back(i);
      total_words += words_for(vectors[base+2], vectors[base+3][1:0]);
    end
    limit = (total_words + 1) * vrf_pkg::NR_QUEUES * 4 + 200;
  endtask

  // Present each queue's next command and random flow control on the falling edge
  task automatic drive_inputs();
    int unsigned base;
    for (int q = 0; q < vrf_pkg::NR_QUEUES; q++) begin
      cmd_valid[q] = (next_cmd[q] < cmd_idx[q].size());
      if (cmd_valid[q]) begin
        base       = cmd_idx[q][next_cmd[q]] * FIELDS;
        cmd_vs[q]  = vectors[base+1][4:0];
        cmd_vl[q]  = vectors[base+2];
        cmd_eew[q] = vrf_pkg::eew_e'(vectors[base+3][1:0]);
      end
      oq_ready[q] = ($urandom % 4) != 0;
    end
    wb_req   = ($urandom % 4) == 0;
    wb_addr  = vrf_pkg::ADDR_W'($urandom);
    wb_wdata = {$urandom, $urandom};
    wb_be    = 8'($urandom);
  endtask

  // Compare the settled outputs with the model on the rising edge and then accept commands
  task automatic check_cycle();
    int unsigned                seen [vrf_pkg::NR_QUEUES];
    int unsigned                tq, wc;
    logic [vrf_pkg::ADDR_W-1:0] flat, start;
    logic [vrf_pkg::BANK_W-1:0] wb_bank;
    wb_bank = wb_addr[vrf_pkg::BANK_W-1:0];
    check_value("wb_gnt_o", wb_req, wb_gnt);
    if (wb_req) begin
      check_value($sformatf("vrf_req_o[%0d]", wb_bank), 1'b1, vrf_req[wb_bank]);
      check_value($sformatf("vrf_wen_o[%0d]", wb_bank), 1'b1, vrf_wen[wb_bank]);
      check_value($sformatf("vrf_addr_o[%0d]", wb_bank),
                  wb_addr[vrf_pkg::ADDR_W-1:vrf_pkg::BANK_W], vrf_addr[wb_bank]);
      check_value($sformatf("vrf_wdata_o[%0d]", wb_bank), wb_wdata, vrf_wdata[wb_bank]);
      check_value($sformatf("vrf_be_o[%0d]", wb_bank), wb_be, vrf_be[wb_bank]);
    end
    for (int q = 0; q < vrf_pkg::NR_QUEUES; q++) seen[q] = 0;
    for (int b = 0; b < vrf_pkg::NR_BANKS; b++) begin
      assert (!vrf_wen[b] || (wb_req && wb_bank == b)) else
        fail_stop($sformatf("Bank %0d was written without a matching write-back", b));
      if (vrf_req[b] && !vrf_wen[b]) begin
        tq   = vrf_tgt[b];
        flat = {vrf_addr[b], vrf_pkg::BANK_W'(b)};
        assert (oq_ready[tq]) else
          fail_stop($sformatf("Queue %0d was read while its operand queue was full", tq));
        assert (exp_addr[tq].size() > 0) else
          fail_stop($sformatf("Queue %0d was read with no operand word outstanding", tq));
        check_value($sformatf("vrf_addr_o[%0d] word of queue %0d", b, tq),
                    exp_addr[tq][0], flat);
        check_value($sformatf("vrf_wdata_o[%0d]", b), '0, vrf_wdata[b]);
        check_value($sformatf("vrf_be_o[%0d]", b), '0, vrf_be[b]);
        void'(exp_addr[tq].pop_front());
        seen[tq]++;
        issued_cnt[tq]++;
      end
    end
    for (int q = 0; q < vrf_pkg::NR_QUEUES; q++) begin
      assert (seen[q] <= 1) else fail_stop($sformatf("Queue %0d got two words in one cycle", q));
      check_value($sformatf("operand_issued_o[%0d]", q), seen[q] != 0, issued[q]);
      // Ready comes back only once the whole operand has been issued
      if (cmd_ready[q] && started[q]) begin
        check_value($sformatf("operand_issued_o[%0d] pulse count", q),
                    cur_words[q], issued_cnt[q]);
      end
      if (cmd_valid[q] && cmd_ready[q]) begin
        wc    = words_for(cmd_vl[q], cmd_eew[q]);
        start = vrf_pkg::ADDR_W'(cmd_vs[q] * vrf_pkg::VREG_WORDS);
        for (int i = 0; i < wc; i++) exp_addr[q].push_back(vrf_pkg::ADDR_W'(start + i));
        cur_words[q]  = wc;
        issued_cnt[q] = 0;
        started[q]    = 1'b1;
        next_cmd[q]++;
      end
    end
  endtask

  function automatic bit all_done();
    bit done;
    done = 1'b1;
    for (int q = 0; q < vrf_pkg::NR_QUEUES; q++) begin
      if (next_cmd[q] < cmd_idx[q].size() || exp_addr[q].size() != 0 || !cmd_ready[q]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : p_main
    void'($urandom(32'h9d30_8650));
    cmd_valid = '0;
    cmd_vs    = '0;
    cmd_vl    = '0;
    // Queues ready so that a requester leaving reset busy would show up
    oq_ready  = '1;
    wb_req    = 1'b0;
    wb_addr   = '0;
    wb_wdata  = '0;
    wb_be     = '0;
    cycles    = 0;
    for (int q = 0; q < vrf_pkg::NR_QUEUES; q++) begin
      cmd_eew[q]    = vrf_pkg::EW8;
      next_cmd[q]   = 0;
      issued_cnt[q] = 0;
      cur_words[q]  = 0;
      started[q]    = 1'b0;
    end
    load_vectors();

    // Idle during reset and on the first edge after it
    do begin
      @(posedge clk);
      check_idle_outputs();
    end while (!rst_n);

    while (!all_done()) begin
      @(negedge clk);
      drive_inputs();
      @(posedge clk);
      cycles++;
      assert (cycles < limit) else
        fail_stop($sformatf("Timeout after %0d cycles with operands still outstanding", cycles));
      check_cycle();
    end

    @(negedge clk);
    cmd_valid = '0;
    oq_ready  = '1;
    wb_req    = 1'b0;
    @(posedge clk);
    check_idle_outputs();
    $display("TEST OK");
    $finish;
  end

endmodule

//--- build.f
hw/vrf_pkg.sv
hw/operand_cmd_decoder.sv
hw/operand_requester.sv
hw/vrf_bank_arbiter.sv
hw/lane_operand_requester.sv
tests/tb_clock_gen.sv
tests/tb_lane_operand_requester.sv

//--- Bender.yml
package:
  name: lane_operand_requester

sources:
  - files:
      - hw/vrf_pkg.sv
      - hw/operand_cmd_decoder.sv
      - hw/operand_requester.sv
      - hw/vrf_bank_arbiter.sv
      - hw/lane_operand_requester.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_lane_operand_requester.sv

//--- tests/operand_tests.mem
// Operand requester tests, one command per line, all fields hex
// queue vs vl eew (eew is log2 of the element bytes)
0 01 10 3
1 02 80 0
2 03 40 1
3 04 20 2
0 05 03 1
1 06 00 2
2 07 21 2
3 08 01 0
0 09 20 3
1 0a 0f 3
2 0b 00 0
3 0c 7f 0
0 0d 11 1
1 0e 08 3
2 0f 05 2
3 10 10 3
0 11 00 3
1 12 40 0
2 13 02 3
3 14 13 2
0 1f 10 3
1 1e 09 1
2 00 80 1
3 1d 00 1
0 10 01 3
1 10 01 3
2 10 01 3
3 10 01 3
